// ==== all.f ====
hw/core_isa_pkg.sv
hw/core_pkg.sv
hw/core_decoder.sv
hw/core_imm_parser.sv
hw/core_alu.sv
hw/core_muldiv.sv
hw/core_pc_new_sel.sv
hw/core_regfile.sv
hw/core_stage_exec.sv
hw/core_exec_top.sv
verification/tb_core_exec.sv

// ==== hw/core_alu.sv ====
`timescale 1ns/1ps

module core_alu import core_pkg::*; (
    input  alu_op_e     alu_op,
    input  logic [31:0] src_a,
    input  logic [31:0] src_b,
    output logic [31:0] alu_result
);

    logic [4:0] shamt;

    assign shamt = src_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:    alu_result = src_a + src_b;
            // Branch compares read this difference as the zero flag
            ALU_SUB:    alu_result = src_a - src_b;
            ALU_AND:    alu_result = src_a & src_b;
            ALU_OR:     alu_result = src_a | src_b;
            ALU_XOR:    alu_result = src_a ^ src_b;
            ALU_SLL:    alu_result = src_a << shamt;
            ALU_SRL:    alu_result = src_a >> shamt;
            ALU_SRA:    alu_result = 32'($signed(src_a) >>> shamt);
            ALU_SLT:    alu_result = {31'b0, $signed(src_a) < $signed(src_b)};
            ALU_SLTU:   alu_result = {31'b0, src_a < src_b};
            ALU_PASS_B: alu_result = src_b;
            default:    alu_result = '0;
        endcase
    end

endmodule

// ==== hw/core_decoder.sv ====
`timescale 1ns/1ps

module core_decoder import core_isa_pkg::*, core_pkg::*; (
    input  instr_u instr,
    output ctrl_t  ctrl
);

    // ALU op from funct3, alt selects SUB or SRA
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    r_fmt_t f;

    assign f = instr.fields;

    always_comb begin
        ctrl = '0;
        case (f.opcode)
            OPC_LUI: begin
                ctrl.imm_type = IMM_U;
                ctrl.exec_src = SRC_REG_IMM;
                ctrl.alu_op   = ALU_PASS_B;
                ctrl.wb_src   = WB_EXEC;
            end
            OPC_AUIPC: begin
                ctrl.imm_type = IMM_U;
                ctrl.exec_src = SRC_PC_IMM;
                ctrl.wb_src   = WB_EXEC;
            end
            OPC_JAL: begin
                ctrl.imm_type = IMM_J;
                ctrl.pc_src   = PC_JAL;
                ctrl.wb_src   = WB_LINK;
            end
            OPC_JALR: begin
                ctrl.imm_type = IMM_I;
                ctrl.exec_src = SRC_REG_IMM;
                ctrl.pc_src   = PC_JALR;
                ctrl.wb_src   = WB_LINK;
            end
            OPC_BRANCH: begin
                // SUB gives the zero flag for eq and ne
                ctrl.imm_type = IMM_B;
                ctrl.alu_op   = ALU_SUB;
                ctrl.pc_src   = PC_BRANCH;
                ctrl.br_type  = br_type_e'(f.funct3);
            end
            OPC_LOAD: begin
                ctrl.imm_type = IMM_I;
                ctrl.exec_src = SRC_REG_IMM;
                ctrl.wb_src   = WB_MEM;
                ctrl.mem_op   = 1'b1;
                ctrl.mem_dir  = MEM_READ;
                ctrl.mem_size = mem_size_e'(f.funct3[1:0]);
            end
            OPC_STORE: begin
                ctrl.imm_type = IMM_S;
                ctrl.exec_src = SRC_REG_IMM;
                ctrl.mem_op   = 1'b1;
                ctrl.mem_dir  = MEM_WRITE;
                ctrl.mem_size = mem_size_e'(f.funct3[1:0]);
            end
            OPC_OP_IMM: begin
                ctrl.imm_type = IMM_I;
                ctrl.exec_src = SRC_REG_IMM;
                // Only SRAI reads funct7
                ctrl.alu_op   = alu_from_funct3(f.funct3, f.funct7[5] && f.funct3 == 3'b101);
                ctrl.wb_src   = WB_EXEC;
            end
            OPC_OP: begin
                ctrl.wb_src = WB_EXEC;
                if (f.funct7 == 7'b0000001) begin
                    ctrl.exec_engine = ENG_MULDIV;
                    ctrl.md_op       = md_op_e'(f.funct3);
                end else begin
                    ctrl.alu_op = alu_from_funct3(f.funct3, f.funct7[5]);
                end
            end
            OPC_SYSTEM: begin
                ctrl.ecall = (instr == 32'h0000_0073);
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== hw/core_exec_top.sv ====
`timescale 1ns/1ps

module core_exec_top import core_isa_pkg::*, core_pkg::*; #(
    parameter int unsigned num_regs = 32
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        instr_valid,
    output logic        instr_ready,
    input  instr_u      instr,
    input  logic [31:0] pc,
    input  logic [31:0] mem_rdata,
    output mem_req_t    mem_req,
    output redirect_t   redirect,
    output logic [31:0] wb_result,
    output logic        reg_wen
);

    logic [4:0]  reg_a_id;
    logic [4:0]  reg_b_id;
    logic [31:0] reg_a_value;
    logic [31:0] reg_b_value;
    wb_req_t     wb_req;

    core_stage_exec u_stage_exec (
        .exec_stage_valid (instr_valid),
        .exec_stage_ready (instr_ready),
        .reg_a_id         (reg_a_id),
        .reg_b_id         (reg_b_id),
        .reg_a_value      (reg_a_value),
        .reg_b_value      (reg_b_value),
        .instr            (instr),
        .pc               (pc),
        .redirect         (redirect),
        .mem_req          (mem_req),
        .wb_req           (wb_req)
    );

    // Write data and enable come back out of the register file
    core_regfile #(
        .num_regs (num_regs)
    ) u_regfile (
        .clk         (clk),
        .arst_n      (arst_n),
        .reg_a_id    (reg_a_id),
        .reg_b_id    (reg_b_id),
        .reg_a_value (reg_a_value),
        .reg_b_value (reg_b_value),
        .wb_req      (wb_req),
        .mem_rdata   (mem_rdata),
        .wb_result   (wb_result),
        .reg_wen     (reg_wen)
    );

endmodule

// ==== hw/core_imm_parser.sv ====
`timescale 1ns/1ps

module core_imm_parser import core_isa_pkg::*, core_pkg::*; (
    input  instr_u      instr,
    input  imm_type_e   imm_type,
    output logic [31:0] imm_val
);

    imm_fmt_t f;

    assign f = instr.imm;

    always_comb begin
        case (imm_type)
            IMM_I: imm_val = {{20{f.imm_hi[6]}}, f.imm_hi, f.imm_mid};
            IMM_S: imm_val = {{20{f.imm_hi[6]}}, f.imm_hi, f.imm_lo};
            IMM_B: imm_val = {{19{f.imm_hi[6]}}, f.imm_hi[6], f.imm_lo[0],
                              f.imm_hi[5:0], f.imm_lo[4:1], 1'b0};
            IMM_U: imm_val = {f.imm_hi, f.imm_mid, f.rs1, f.funct3, 12'b0};
            // J layout spreads bits over rs1, funct3 and the rs2 slot
            IMM_J: imm_val = {{11{f.imm_hi[6]}}, f.imm_hi[6], f.rs1, f.funct3,
                              f.imm_mid[0], f.imm_hi[5:0], f.imm_mid[4:1], 1'b0};
            default: imm_val = '0;
        endcase
    end

endmodule

// ==== hw/core_isa_pkg.sv ====
package core_isa_pkg;

    // RV32 major opcodes
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // Register view of the instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // Immediate view, covers the I, S and B field positions
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] imm_mid;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } imm_fmt_t;

    typedef union packed {
        r_fmt_t   fields;
        imm_fmt_t imm;
    } instr_u;

endpackage

// ==== hw/core_muldiv.sv ====
`timescale 1ns/1ps

module core_muldiv import core_pkg::*; (
    input  md_op_e      md_op,
    input  logic [31:0] src_a,
    input  logic [31:0] src_b,
    output logic [31:0] md_result
);

    logic               a_signed;
    logic               b_signed;
    logic signed [32:0] op_a;
    logic signed [32:0] op_b;
    logic signed [65:0] product;
    logic               div_zero;
    logic               div_ovf;
    logic [31:0]        quot_s;
    logic [31:0]        rem_s;
    logic [31:0]        quot_u;
    logic [31:0]        rem_u;

    // One 33x33 signed multiplier covers all four products
    assign a_signed = (md_op == MD_MULH) || (md_op == MD_MULHSU);
    assign b_signed = (md_op == MD_MULH);
    assign op_a     = {a_signed & src_a[31], src_a};
    assign op_b     = {b_signed & src_b[31], src_b};
    assign product  = op_a * op_b;

    assign div_zero = (src_b == '0);
    assign div_ovf  = (src_a == 32'h8000_0000) && (src_b == '1);
    assign quot_s   = $signed(src_a) / $signed(src_b);
    assign rem_s    = $signed(src_a) % $signed(src_b);
    assign quot_u   = src_a / src_b;
    assign rem_u    = src_a % src_b;

    always_comb begin
        case (md_op)
            MD_MUL:    md_result = product[31:0];
            MD_MULH,
            MD_MULHSU,
            MD_MULHU:  md_result = product[63:32];
            MD_DIV:    md_result = div_zero ? '1 : (div_ovf ? src_a : quot_s);
            MD_DIVU:   md_result = div_zero ? '1 : quot_u;
            MD_REM:    md_result = div_zero ? src_a : (div_ovf ? '0 : rem_s);
            default:   md_result = div_zero ? src_a : rem_u;
        endcase
    end

endmodule

// ==== hw/core_pc_new_sel.sv ====
`timescale 1ns/1ps

module core_pc_new_sel import core_pkg::*; (
    input  pc_src_e     pc_src,
    input  br_type_e    br_type,
    input  logic [31:0] src_a,
    input  logic [31:0] src_b,
    input  logic [31:0] alu_result,
    input  logic [31:0] br_target,
    output redirect_t   redirect
);

    logic eq;
    logic lt;
    logic ltu;
    logic taken;

    assign eq  = (alu_result == '0);
    assign lt  = $signed(src_a) < $signed(src_b);
    assign ltu = src_a < src_b;

    always_comb begin
        case (br_type)
            BR_EQ:   taken = eq;
            BR_NE:   taken = !eq;
            BR_LT:   taken = lt;
            BR_GE:   taken = !lt;
            BR_LTU:  taken = ltu;
            BR_GEU:  taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (pc_src)
            PC_BRANCH: redirect = '{valid: taken, target: br_target};
            PC_JAL:    redirect = '{valid: 1'b1, target: br_target};
            PC_JALR:   redirect = '{valid: 1'b1, target: {alu_result[31:1], 1'b0}};
            default:   redirect = '{valid: 1'b0, target: br_target};
        endcase
    end

endmodule

// ==== hw/core_pkg.sv ====
package core_pkg;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_type_e;

    typedef enum logic [1:0] {
        SRC_REG_REG, SRC_REG_IMM, SRC_PC_IMM
    } exec_src_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
    } alu_op_e;

    // Encoded as funct3 of the M extension
    typedef enum logic [2:0] {
        MD_MUL, MD_MULH, MD_MULHSU, MD_MULHU, MD_DIV, MD_DIVU, MD_REM, MD_REMU
    } md_op_e;

    typedef enum logic [1:0] {
        ENG_ALU, ENG_MULDIV
    } exec_engine_e;

    typedef enum logic [1:0] {
        PC_NEXT, PC_BRANCH, PC_JAL, PC_JALR
    } pc_src_e;

    // Encoded as funct3 of the branch instructions
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_type_e;

    typedef enum logic [1:0] {
        WB_NONE, WB_EXEC, WB_MEM, WB_LINK
    } wb_src_e;

    typedef enum logic {
        MEM_READ, MEM_WRITE
    } mem_dir_e;

    typedef enum logic [1:0] {
        MEM_BYTE, MEM_HALF, MEM_WORD
    } mem_size_e;

    // All zero is the idle control word
    typedef struct packed {
        imm_type_e    imm_type;
        exec_src_e    exec_src;
        alu_op_e      alu_op;
        md_op_e       md_op;
        exec_engine_e exec_engine;
        pc_src_e      pc_src;
        br_type_e     br_type;
        wb_src_e      wb_src;
        logic         mem_op;
        mem_dir_e     mem_dir;
        mem_size_e    mem_size;
        logic         ecall;
    } ctrl_t;

    typedef struct packed {
        logic        op;
        logic [31:0] addr;
        logic [31:0] wdata;
        mem_dir_e    dir;
        mem_size_e   size;
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

    typedef struct packed {
        logic        wen;
        logic [4:0]  rd;
        wb_src_e     src;
        logic [31:0] exec_result;
        logic [31:0] link;
    } wb_req_t;

endpackage

// ==== hw/core_regfile.sv ====
`timescale 1ns/1ps

module core_regfile import core_pkg::*; #(
    parameter int unsigned num_regs = 32
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [4:0]  reg_a_id,
    input  logic [4:0]  reg_b_id,
    output logic [31:0] reg_a_value,
    output logic [31:0] reg_b_value,
    input  wb_req_t     wb_req,
    input  logic [31:0] mem_rdata,
    output logic [31:0] wb_result,
    output logic        reg_wen
);

    localparam int unsigned idx_w = $clog2(num_regs);

    logic [31:0] regs [num_regs];
    logic        a_live;
    logic        b_live;
    logic        wr_live;

    // x0 and ids past num_regs read as zero
    assign a_live  = (reg_a_id != '0) && (32'(reg_a_id) < num_regs);
    assign b_live  = (reg_b_id != '0) && (32'(reg_b_id) < num_regs);
    assign wr_live = (32'(wb_req.rd) < num_regs);

    assign reg_a_value = a_live ? regs[reg_a_id[idx_w-1:0]] : '0;
    assign reg_b_value = b_live ? regs[reg_b_id[idx_w-1:0]] : '0;

    // Write data by source
    always_comb begin
        case (wb_req.src)
            WB_MEM:  wb_result = mem_rdata;
            WB_LINK: wb_result = wb_req.link;
            default: wb_result = wb_req.exec_result;
        endcase
    end

    assign reg_wen = wb_req.wen;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '{default: '0};
        end else if (reg_wen && wr_live) begin
            regs[wb_req.rd[idx_w-1:0]] <= wb_result;
        end
    end

endmodule

// ==== hw/core_stage_exec.sv ====
`timescale 1ns/1ps

module core_stage_exec import core_isa_pkg::*, core_pkg::*; (
    input  logic        exec_stage_valid,
    output logic        exec_stage_ready,
    output logic [4:0]  reg_a_id,
    output logic [4:0]  reg_b_id,
    input  logic [31:0] reg_a_value,
    input  logic [31:0] reg_b_value,
    input  instr_u      instr,
    input  logic [31:0] pc,
    output redirect_t   redirect,
    output mem_req_t    mem_req,
    output wb_req_t     wb_req
);

    ctrl_t       ctrl;
    logic [31:0] imm_val;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [31:0] alu_result;
    logic [31:0] md_result;
    logic [31:0] br_target;
    redirect_t   pc_redirect;
    logic        fire;

    // ECALL stalls the stage for good
    assign exec_stage_ready = !ctrl.ecall;
    assign fire             = exec_stage_valid && exec_stage_ready;

    assign reg_a_id = instr.fields.rs1;
    assign reg_b_id = instr.fields.rs2;

    core_decoder u_decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    core_imm_parser u_imm_parser (
        .instr    (instr),
        .imm_type (ctrl.imm_type),
        .imm_val  (imm_val)
    );

    // Operand select
    always_comb begin
        case (ctrl.exec_src)
            SRC_REG_IMM: begin
                src_a = reg_a_value;
                src_b = imm_val;
            end
            SRC_PC_IMM: begin
                src_a = pc;
                src_b = imm_val;
            end
            default: begin
                src_a = reg_a_value;
                src_b = reg_b_value;
            end
        endcase
    end

    core_alu u_alu (
        .alu_op     (ctrl.alu_op),
        .src_a      (src_a),
        .src_b      (src_b),
        .alu_result (alu_result)
    );

    core_muldiv u_muldiv (
        .md_op     (ctrl.md_op),
        .src_a     (src_a),
        .src_b     (src_b),
        .md_result (md_result)
    );

    // Branch and JAL share the pc relative target
    assign br_target = pc + imm_val;

    core_pc_new_sel u_pc_new_sel (
        .pc_src     (ctrl.pc_src),
        .br_type    (ctrl.br_type),
        .src_a      (src_a),
        .src_b      (src_b),
        .alu_result (alu_result),
        .br_target  (br_target),
        .redirect   (pc_redirect)
    );

    assign redirect.valid  = pc_redirect.valid && fire;
    assign redirect.target = pc_redirect.target;

    assign mem_req.op    = ctrl.mem_op && fire;
    assign mem_req.addr  = alu_result;
    assign mem_req.wdata = reg_b_value;
    assign mem_req.dir   = ctrl.mem_dir;
    assign mem_req.size  = ctrl.mem_size;

    // No write for x0 or for instructions without a result
    assign wb_req.wen         = fire && (ctrl.wb_src != WB_NONE) && (instr.fields.rd != '0);
    assign wb_req.rd          = instr.fields.rd;
    assign wb_req.src         = ctrl.wb_src;
    assign wb_req.exec_result = (ctrl.exec_engine == ENG_MULDIV) ? md_result : alu_result;
    assign wb_req.link        = pc + 32'd4;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_core_exec -f all.f -o sim_core_exec

output="$(./obj_dir/sim_core_exec)"
echo "$output"

if grep -qx "STATUS: PASS" <<< "$output"; then
    exit 0
fi
exit 1

// ==== verification/exec_stim.txt ====
// instr pc rdata | ready wen wb_result | rvalid rtarget | mop addr wdata dir size
// First word is the vector count; columns after a low flag are don't care
1F
00500093 00000100 00000000 1 1 00000005 0 00000000 0 00000000 00000000 0 0
FFD00113 00000104 00000000 1 1 FFFFFFFD 0 00000000 0 00000000 00000000 0 0
800001B7 00000108 00000000 1 1 80000000 0 00000000 0 00000000 00000000 0 0
00208233 0000010C 00000000 1 1 00000002 0 00000000 0 00000000 00000000 0 0
402082B3 00000110 00000000 1 1 00000008 0 00000000 0 00000000 00000000 0 0
00112333 00000114 00000000 1 1 00000001 0 00000000 0 00000000 00000000 0 0
001133B3 00000118 00000000 1 1 00000000 0 00000000 0 00000000 00000000 0 0
4041D413 0000011C 00000000 1 1 F8000000 0 00000000 0 00000000 00000000 0 0
0F014493 00000120 00000000 1 1 FFFFFF0D 0 00000000 0 00000000 00000000 0 0
02208533 00000124 00000000 1 1 FFFFFFF1 0 00000000 0 00000000 00000000 0 0
023195B3 00000128 00000000 1 1 40000000 0 00000000 0 00000000 00000000 0 0
02113633 0000012C 00000000 1 1 00000004 0 00000000 0 00000000 00000000 0 0
0200C6B3 00000130 00000000 1 1 FFFFFFFF 0 00000000 0 00000000 00000000 0 0
0200E733 00000134 00000000 1 1 00000005 0 00000000 0 00000000 00000000 0 0
FFF00793 00000138 00000000 1 1 FFFFFFFF 0 00000000 0 00000000 00000000 0 0
02F1C833 0000013C 00000000 1 1 80000000 0 00000000 0 00000000 00000000 0 0
02F1E8B3 00000140 00000000 1 1 00000000 0 00000000 0 00000000 00000000 0 0
02115933 00000144 00000000 1 1 33333332 0 00000000 0 00000000 00000000 0 0
021179B3 00000148 00000000 1 1 00000003 0 00000000 0 00000000 00000000 0 0
00108863 0000014C 00000000 1 0 00000000 1 0000015C 0 00000000 00000000 0 0
00109863 00000150 00000000 1 0 00000000 0 00000000 0 00000000 00000000 0 0
FE114CE3 00000154 00000000 1 0 00000000 1 0000014C 0 00000000 00000000 0 0
00117463 00000158 00000000 1 0 00000000 1 00000160 0 00000000 00000000 0 0
0020F463 0000015C 00000000 1 0 00000000 0 00000000 0 00000000 00000000 0 0
02000A6F 00000160 00000000 1 1 00000164 1 00000180 0 00000000 00000000 0 0
02008AE7 00000164 00000000 1 1 00000168 1 00000024 0 00000000 00000000 0 0
0020A623 00000168 00000000 1 0 00000000 0 00000000 1 00000011 FFFFFFFD 1 2
0040AB03 0000016C 5A5A1234 1 1 5A5A1234 0 00000000 1 00000009 00000002 0 2
00208033 00000170 00000000 1 0 00000000 0 00000000 0 00000000 00000000 0 0
01600BB3 00000174 00000000 1 1 5A5A1234 0 00000000 0 00000000 00000000 0 0
00000073 00000178 00000000 0 0 00000000 0 00000000 0 00000000 00000000 0 0

// ==== verification/tb_core_exec.sv ====
`timescale 1ns/1ps

module tb_core_exec import core_isa_pkg::*, core_pkg::*; ();

    localparam int unsigned fields        = 13;
    localparam int unsigned max_vectors   = 64;
    localparam int unsigned ready_timeout = 10;
    localparam int unsigned stall_cycles  = 5;

    // One line of the stim file, every column widened to 32 bits
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] rdata;
        logic [31:0] ready;
        logic [31:0] wen;
        logic [31:0] wb;
        logic [31:0] rvalid;
        logic [31:0] rtarget;
        logic [31:0] mop;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] dir;
        logic [31:0] size;
    } vector_t;

    logic        clk;
    logic        arst_n;
    logic        instr_valid;
    logic        instr_ready;
    instr_u      instr;
    logic [31:0] pc;
    logic [31:0] mem_rdata;
    mem_req_t    mem_req;
    redirect_t   redirect;
    logic [31:0] wb_result;
    logic        reg_wen;

    logic [31:0] stim [1024];
    vector_t     cur;
    int unsigned mismatches;
    int unsigned failures;

    core_exec_top #(
        .num_regs (32)
    ) u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .pc          (pc),
        .mem_rdata   (mem_rdata),
        .mem_req     (mem_req),
        .redirect    (redirect),
        .wb_result   (wb_result),
        .reg_wen     (reg_wen)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Word 0 of the file is the count, vectors follow
    task automatic load_vector(input int unsigned vec);
        logic [9:0]  pos;
        int unsigned k;
        pos = 10'(1 + vec * fields);
        for (k = 0; k < fields; k++) begin
            cur = {cur[383:0], stim[pos]};
            pos++;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            mismatches++;
            $display("mismatch at %0t ns: %s expected %h got %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic wait_ready();
        int unsigned waited;
        waited = 0;
        while (!instr_ready && waited < ready_timeout) begin
            @(negedge clk);
            waited++;
        end
        assert (instr_ready) else begin
            failures++;
            $display("instr_ready still low after %0d cycles at %0t ns", ready_timeout, $time);
        end
    endtask

    // Dependent fields only matter when their flag is set
    task automatic check_retire();
        check_value("reg_wen", cur.wen, 32'(reg_wen));
        if (cur.wen[0]) begin
            check_value("wb_result", cur.wb, wb_result);
        end
        check_value("redirect.valid", cur.rvalid, 32'(redirect.valid));
        if (cur.rvalid[0]) begin
            check_value("redirect.target", cur.rtarget, redirect.target);
        end
        check_value("mem_req.op", cur.mop, 32'(mem_req.op));
        if (cur.mop[0]) begin
            check_value("mem_req.addr", cur.addr, mem_req.addr);
            check_value("mem_req.wdata", cur.wdata, mem_req.wdata);
            check_value("mem_req.dir", cur.dir, 32'(mem_req.dir));
            check_value("mem_req.size", cur.size, 32'(mem_req.size));
        end
    endtask

    // Inputs stay as driven, so the stalled instruction is held
    task automatic check_stall();
        int unsigned cyc;
        for (cyc = 0; cyc < stall_cycles; cyc++) begin
            check_value("instr_ready", cur.ready, 32'(instr_ready));
            check_value("reg_wen", cur.wen, 32'(reg_wen));
            check_value("redirect.valid", cur.rvalid, 32'(redirect.valid));
            check_value("mem_req.op", cur.mop, 32'(mem_req.op));
            @(negedge clk);
        end
    endtask

    initial begin
        int unsigned count;
        int unsigned vec;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        mem_rdata   = '0;
        mismatches  = 0;
        failures    = 0;
        $readmemh("verification/exec_stim.txt", stim);
        count = stim[0];
        assert (count > 0 && count <= max_vectors) else begin
            failures++;
            $display("stim file holds %0d vectors, expected 1 to %0d", count, max_vectors);
            count = 0;
        end

        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        for (vec = 0; vec < count; vec++) begin
            load_vector(vec);
            @(posedge clk);
            instr_valid <= 1'b1;
            instr       <= cur.instr;
            pc          <= cur.pc;
            mem_rdata   <= cur.rdata;
            // Mid-cycle sample, outputs are settled
            @(negedge clk);
            if (cur.ready[0]) begin
                wait_ready();
                check_retire();
            end else begin
                check_stall();
            end
        end

        $display("mismatches: %0d, other errors: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
